// File: Bender.yml
package:
  name: zx_mem_io

sources:
  - hw/zx_bus_pkg.sv
  - hw/zx_arch_pkg.sv
  - hw/zx_io_if.sv
  - hw/zx_mem_if.sv
  - hw/zx_page_if.sv
  - hw/zx_cpu_bus.sv
  - hw/zx_paging.sv
  - hw/zx_mem_map.sv
  - hw/zx_ula_io.sv
  - hw/zx_mem_io.sv
  - target: test
    files:
      - verification/zx_mem_io_tb.sv

// File: hw/zx_arch_pkg.sv
// Architecture package for the Spectrum memory and I/O core
// Machine and joystick selections and the fixed banks of the memory map
`default_nettype none

package zx_arch_pkg;

	// Machine family, latched at reset
	typedef enum logic [1:0] {
		zx48,
		zx128,      // 128K and +2
		zx_plus3    // +2A and +3
	} machine_e;

	typedef enum logic [1:0] {
		joy_kempston,
		joy_sinclair1,  // Keys 6..0
		joy_sinclair2   // Keys 1..5
	} joy_mode_e;

	// ============================================================
	// Memory map
	// ============================================================

	localparam zx_bus_pkg::bank_t ROM_BANK_BASE      = 6'd32;  // ROM n at 32 + n
	localparam zx_bus_pkg::bank_t BANK_AT_4000       = 6'd5;
	localparam zx_bus_pkg::bank_t BANK_AT_8000       = 6'd2;
	localparam zx_bus_pkg::bank_t SCREEN_BANK_NORMAL = 6'd5;
	localparam zx_bus_pkg::bank_t SCREEN_BANK_SHADOW = 6'd7;

endpackage

`default_nettype wire

// File: hw/zx_bus_pkg.sv
// Bus package for the Spectrum memory and I/O core
// CPU bus, bank and RAM address types plus fixed port decode values
`default_nettype none

package zx_bus_pkg;

	// ============================================================
	// Widths that carry a meaning
	// ============================================================

	typedef logic [15:0] cpu_addr_t;     // Z80 address bus
	typedef logic [7:0]  cpu_data_t;     // Z80 data byte

	typedef logic [5:0]  bank_t;         // RAM and ROM share one bank space
	typedef logic [13:0] bank_offset_t;  // 16K window inside a bank

	// Bank above offset, so each 16K bank is linear in RAM
	typedef logic [19:0] ram_addr_t;

	// ============================================================
	// Port decoding
	// ============================================================

	// Kempston answers on the low address byte only
	localparam cpu_data_t PORT_KEMPSTON = 8'h1F;

	// Floating bus value when nothing drives the data lines
	localparam cpu_data_t IO_READ_IDLE = 8'hFF;

endpackage

`default_nettype wire

// File: hw/zx_cpu_bus.sv
// CPU bus front end
// Turns Z80 strobes into memory requests and I/O cycles, stalls the CPU on wait
`default_nettype none

module zx_cpu_bus import zx_bus_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      reset,
	input  wire cpu_addr_t cpu_addr,
	input  wire cpu_data_t cpu_wdata,
	output cpu_data_t      cpu_rdata,
	input  wire logic      cpu_mreq,
	input  wire logic      cpu_iorq,
	input  wire logic      cpu_rd,
	input  wire logic      cpu_wr,
	input  wire logic      cpu_m1,
	output logic           cpu_wait,
	zx_io_if.bus           io,
	zx_mem_if.cpu          mem
);

	logic      mem_acc, mem_acc_q, mem_start;
	logic      io_wr, io_wr_q;
	logic      wait_q;
	logic      req_valid_q;
	cpu_addr_t req_addr_q;
	cpu_data_t req_wdata_q;
	logic      req_we_q;
	cpu_data_t rdata_q;

	assign mem_acc   = cpu_mreq & (cpu_rd | cpu_wr);
	assign mem_start = mem_acc & ~mem_acc_q;
	assign io_wr     = cpu_iorq & cpu_wr & ~cpu_m1;  // Skip interrupt acknowledge

	// ============================================================
	// Access tracking
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_acc_q   <= 1'b0;
			io_wr_q     <= 1'b0;
			wait_q      <= 1'b0;
			req_valid_q <= 1'b0;
		end else begin
			mem_acc_q <= mem_acc;
			io_wr_q   <= io_wr;
			if (mem.rsp_valid)
				wait_q <= 1'b0;
			if (mem_start) begin
				wait_q      <= 1'b1;
				req_valid_q <= 1'b1;
			end else if (req_valid_q && mem.req_ready) begin
				req_valid_q <= 1'b0;
			end
		end
	end

	// Request fields frozen for the handshake
	always_ff @(posedge clk_sys) begin
		if (mem_start) begin
			req_addr_q  <= cpu_addr;
			req_wdata_q <= cpu_wdata;
			req_we_q    <= cpu_wr;
		end
		if (mem.rsp_valid)
			rdata_q <= mem.rsp_rdata;
	end

	assign mem.req_valid = req_valid_q;
	assign mem.addr      = req_addr_q;
	assign mem.wdata     = req_wdata_q;
	assign mem.we        = req_we_q;

	assign cpu_wait = wait_q & ~mem.rsp_valid;  // Released as the response lands

	assign io.wr_stb = io_wr & ~io_wr_q;
	assign io.rd     = cpu_iorq & cpu_rd & ~cpu_m1;
	assign io.addr   = cpu_addr;
	assign io.wdata  = cpu_wdata;

	// Read data back to the CPU
	always_comb begin
		if (cpu_mreq && cpu_rd)
			cpu_rdata = mem.rsp_valid ? mem.rsp_rdata : rdata_q;
		else if (io.rd)
			cpu_rdata = io.rdata;
		else
			cpu_rdata = IO_READ_IDLE;
	end

	a_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		mem.req_valid && !mem.req_ready |=> mem.req_valid);

endmodule

`default_nettype wire

// File: hw/zx_io_if.sv
// One decoded CPU I/O cycle, from the bus front end to the port blocks
`default_nettype none

interface zx_io_if import zx_bus_pkg::*; ();

	logic      wr_stb;  // One cycle per I/O write
	logic      rd;      // Level for the whole I/O read
	cpu_addr_t addr;
	cpu_data_t wdata;
	cpu_data_t rdata;   // Driven by the ULA block

	modport bus (
		output wr_stb, rd, addr, wdata,
		input  rdata
	);

	modport port_rw (
		input  wr_stb, rd, addr, wdata,
		output rdata
	);

	// Paging registers are write only
	modport port_wr (
		input wr_stb, addr, wdata
	);

endinterface

`default_nettype wire

// File: hw/zx_mem_if.sv
// CPU memory request and its completion, bus front end to mapper
`default_nettype none

interface zx_mem_if import zx_bus_pkg::*; ();

	logic      req_valid;
	logic      req_ready;
	cpu_addr_t addr;
	cpu_data_t wdata;
	logic      we;

	logic      rsp_valid;  // One pulse per accepted request
	cpu_data_t rsp_rdata;

	modport cpu (
		output req_valid, addr, wdata, we,
		input  req_ready, rsp_valid, rsp_rdata
	);

	modport map (
		input  req_valid, addr, wdata, we,
		output req_ready, rsp_valid, rsp_rdata
	);

endinterface

`default_nettype wire

// File: hw/zx_mem_io.sv
// Spectrum 128K-family memory and I/O core
// Bus front end, paging, memory mapper and ULA ports
`default_nettype none

module zx_mem_io import zx_bus_pkg::*, zx_arch_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire machine_e   machine,
	// Z80 bus, active high
	input  wire cpu_addr_t  cpu_addr,
	input  wire cpu_data_t  cpu_wdata,
	output cpu_data_t       cpu_rdata,
	input  wire logic       cpu_mreq,
	input  wire logic       cpu_iorq,
	input  wire logic       cpu_rd,
	input  wire logic       cpu_wr,
	input  wire logic       cpu_m1,
	output logic            cpu_wait,
	// External RAM
	output logic            ram_valid,
	input  wire logic       ram_ready,
	output ram_addr_t       ram_addr,
	output cpu_data_t       ram_wdata,
	output logic            ram_we,
	input  wire cpu_data_t  ram_rdata,
	// ULA side
	input  wire logic [4:0] kbd_cols,
	input  wire logic       ear_in,
	input  wire joy_mode_e  joy_mode,
	input  wire logic [4:0] joy_state,
	output logic [2:0]      border,
	output logic            ear_out,
	output logic            mic_out,
	output bank_t           screen_bank
);

	zx_io_if   io_if_i ();
	zx_mem_if  mem_if_i ();
	zx_page_if page_if_i ();

	zx_cpu_bus zx_cpu_bus_i (
		.clk_sys, .reset, .cpu_addr, .cpu_wdata, .cpu_rdata,
		.cpu_mreq, .cpu_iorq, .cpu_rd, .cpu_wr, .cpu_m1, .cpu_wait,
		.io(io_if_i), .mem(mem_if_i)
	);

	zx_paging zx_paging_i (
		.clk_sys, .reset, .machine, .io(io_if_i), .page(page_if_i), .screen_bank
	);

	zx_mem_map zx_mem_map_i (
		.clk_sys, .reset, .mem(mem_if_i), .page(page_if_i),
		.ram_valid, .ram_ready, .ram_addr, .ram_wdata, .ram_we, .ram_rdata
	);

	zx_ula_io zx_ula_io_i (
		.clk_sys, .reset, .io(io_if_i), .kbd_cols, .ear_in, .joy_mode, .joy_state,
		.border, .ear_out, .mic_out
	);

endmodule

`default_nettype wire

// File: hw/zx_mem_map.sv
// Memory mapper
// Translates CPU addresses to bank-linear RAM addresses, drops ROM writes
`default_nettype none

module zx_mem_map import zx_bus_pkg::*, zx_arch_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      reset,
	zx_mem_if.map          mem,
	zx_page_if.dst         page,
	output logic           ram_valid,
	input  wire logic      ram_ready,
	output ram_addr_t      ram_addr,
	output cpu_data_t      ram_wdata,
	output logic           ram_we,
	input  wire cpu_data_t ram_rdata
);

	logic [1:0]   slot;
	bank_t        bank;
	bank_offset_t offset;
	logic         rom_write;
	logic         accept;
	logic         rsp_valid_q;
	cpu_data_t    rsp_rdata_q;

	assign slot      = mem.addr[15:14];
	assign offset    = mem.addr[13:0];
	assign rom_write = mem.we & ~page.special & (slot == 2'd0);

	always_comb begin
		if (page.special) begin
			// +3 all-RAM layouts
			case ({page.special_cfg, slot})
				4'b00_00: bank = 6'd0;
				4'b00_01: bank = 6'd1;
				4'b00_10: bank = 6'd2;
				4'b00_11: bank = 6'd3;
				4'b01_11: bank = 6'd7;
				4'b10_11: bank = 6'd3;
				4'b11_01: bank = 6'd7;
				4'b11_11: bank = 6'd3;
				default:  bank = {4'd1, slot};  // Slots 4,5,6 pattern
			endcase
		end else begin
			case (slot)
				2'd0:    bank = ROM_BANK_BASE + {4'd0, page.rom_sel};
				2'd1:    bank = BANK_AT_4000;
				2'd2:    bank = BANK_AT_8000;
				default: bank = page.ram_top;
			endcase
		end
	end

	assign mem.req_ready = ~ram_valid;
	assign accept        = mem.req_valid & ~ram_valid;

	// ============================================================
	// Output register towards RAM
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_valid   <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= 1'b0;
			if (accept) begin
				ram_valid   <= ~rom_write;
				rsp_valid_q <= rom_write;  // Acked but never sent
			end else if (ram_valid && ram_ready) begin
				ram_valid   <= 1'b0;
				rsp_valid_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			ram_addr  <= {bank, offset};
			ram_wdata <= mem.wdata;
			ram_we    <= mem.we;
		end
		if (ram_valid && ram_ready)
			rsp_rdata_q <= ram_rdata;
	end

	assign mem.rsp_valid = rsp_valid_q;
	assign mem.rsp_rdata = rsp_rdata_q;

	a_ram_stable: assert property (@(posedge clk_sys) disable iff (reset)
		ram_valid && !ram_ready |=> ram_valid && $stable(ram_addr)
			&& $stable(ram_wdata) && $stable(ram_we));

endmodule

`default_nettype wire

// File: hw/zx_page_if.sv
// Current paging state from the register block to the mapper
`default_nettype none

interface zx_page_if import zx_bus_pkg::*; ();

	bank_t      ram_top;      // Bank seen at C000
	logic [1:0] rom_sel;
	logic       special;      // +3 all-RAM mode
	logic [1:0] special_cfg;

	modport src (output ram_top, rom_sel, special, special_cfg);
	modport dst (input  ram_top, rom_sel, special, special_cfg);

endinterface

`default_nettype wire

// File: hw/zx_paging.sv
// Paging registers 7FFD and 1FFD
// Holds RAM and ROM selection, shadow screen, +3 special mode and the lock
`default_nettype none

module zx_paging import zx_bus_pkg::*, zx_arch_pkg::*; (
	input  wire logic     clk_sys,
	input  wire logic     reset,
	input  wire machine_e machine,
	zx_io_if.port_wr      io,
	zx_page_if.src        page,
	output bank_t         screen_bank
);

	machine_e   machine_q;
	logic [2:0] ram_bank_q;
	logic       shadow_q;
	logic       rom_lo_q;
	logic       lock_q;
	logic       special_q;
	logic [1:0] special_cfg_q;  // Bit 1 doubles as ROM high bit

	logic is_plus3;
	logic page_disable;
	logic sel_7ffd, sel_1ffd;

	assign is_plus3     = (machine_q == zx_plus3);
	assign page_disable = lock_q | (machine_q == zx48);

	// 128K decodes loosely, +3 also needs A14
	assign sel_7ffd = ~io.addr[15] & ~io.addr[1] & (io.addr[14] | ~is_plus3);
	assign sel_1ffd = is_plus3 & (io.addr[15:12] == 4'b0001) & ~io.addr[1];

	// ============================================================
	// Register writes
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine_q     <= machine;  // Tracks the selection while in reset
			ram_bank_q    <= 3'd0;
			shadow_q      <= 1'b0;
			rom_lo_q      <= 1'b0;
			lock_q        <= 1'b0;
			special_q     <= 1'b0;
			special_cfg_q <= 2'b00;
		end else if (io.wr_stb && !page_disable) begin
			if (sel_7ffd) begin
				ram_bank_q <= io.wdata[2:0];
				shadow_q   <= io.wdata[3];
				rom_lo_q   <= io.wdata[4];
				lock_q     <= io.wdata[5];
			end else if (sel_1ffd) begin
				special_q     <= io.wdata[0];
				special_cfg_q <= io.wdata[2:1];
			end
		end
	end

	assign page.ram_top     = {3'b000, ram_bank_q};
	assign page.special     = special_q;
	assign page.special_cfg = special_cfg_q;

	always_comb begin
		case (machine_q)
			zx48:     page.rom_sel = 2'd1;  // 48 BASIC only
			zx128:    page.rom_sel = {1'b0, rom_lo_q};
			default:  page.rom_sel = {special_cfg_q[1], rom_lo_q};
		endcase
	end

	assign screen_bank = shadow_q ? SCREEN_BANK_SHADOW : SCREEN_BANK_NORMAL;

	a_special_plus3: assert property (@(posedge clk_sys) disable iff (reset)
		page.special |-> machine_q == zx_plus3);

endmodule

`default_nettype wire

// File: hw/zx_ula_io.sv
// ULA port FE and Kempston port 1F
// Border, EAR and MIC outputs, keyboard read with Sinclair joystick keys merged in
`default_nettype none

module zx_ula_io import zx_bus_pkg::*, zx_arch_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	zx_io_if.port_rw        io,
	input  wire logic [4:0] kbd_cols,   // Active low
	input  wire logic       ear_in,
	input  wire joy_mode_e  joy_mode,
	input  wire logic [4:0] joy_state,  // Fire, up, down, left, right from bit 4
	output logic [2:0]      border,
	output logic            ear_out,
	output logic            mic_out
);

	logic [4:0] keys_s1, keys_s2;
	logic [4:0] kbd_read;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (io.wr_stb && !io.addr[0]) begin
			border  <= io.wdata[2:0];
			mic_out <= io.wdata[3];
			ear_out <= io.wdata[4];
		end
	end

	// Sinclair I on row 6..0, selected by A12
	assign keys_s1 = (joy_mode == joy_sinclair1 && !io.addr[12])
		? {joy_state[1], joy_state[0], joy_state[2], joy_state[3], joy_state[4]}
		: 5'b00000;
	// Sinclair II on row 1..5, selected by A11
	assign keys_s2 = (joy_mode == joy_sinclair2 && !io.addr[11])
		? {joy_state[4], joy_state[3], joy_state[2], joy_state[0], joy_state[1]}
		: 5'b00000;

	assign kbd_read = kbd_cols & ~(keys_s1 | keys_s2);

	always_comb begin
		if (!io.rd)
			io.rdata = IO_READ_IDLE;
		else if (!io.addr[0])
			io.rdata = {1'b1, ear_in, 1'b1, kbd_read};
		else if (io.addr[7:0] == PORT_KEMPSTON)
			io.rdata = (joy_mode == joy_kempston) ? {3'b000, joy_state} : 8'h00;
		else
			io.rdata = IO_READ_IDLE;
	end

endmodule

`default_nettype wire

// File: verification/zx_mem_io_tb.sv
// Testbench for the Spectrum memory and I/O core
// Drives CPU memory and I/O cycles against a RAM model with random ready delay
`default_nettype none

module zx_mem_io_tb import zx_bus_pkg::*, zx_arch_pkg::*; ();

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 5;
	localparam int ACCESS_LIMIT    = 16;  // Cycles before an access counts as hung
	localparam int RANDOM_ACCESSES = 32;
	localparam int ULA_READS       = 12;
	// Upper bound on the run length in cycles
	localparam int MEM_ACCESSES    = RANDOM_ACCESSES + 40;
	localparam int IO_OPS          = ULA_READS + 30;
	localparam int RUN_CYCLES      = MEM_ACCESSES * ACCESS_LIMIT + IO_OPS * 3
		+ 4 * (RESET_CYCLES + 2) + 200;

	logic       clk_sys;
	logic       reset;
	machine_e   machine;
	cpu_addr_t  cpu_addr;
	cpu_data_t  cpu_wdata;
	cpu_data_t  cpu_rdata;
	logic       cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, cpu_m1;
	logic       cpu_wait;
	logic       ram_valid, ram_ready;
	ram_addr_t  ram_addr;
	cpu_data_t  ram_wdata, ram_rdata;
	logic       ram_we;
	logic [4:0] kbd_cols;
	logic       ear_in;
	joy_mode_e  joy_mode;
	logic [4:0] joy_state;  // Fire, up, down, left, right from bit 4
	logic [2:0] border;
	logic       ear_out, mic_out;
	bank_t      screen_bank;

	int          error_count = 0;
	int          check_count = 0;
	logic [15:0] stim_lfsr   = 16'd18843;
	logic [15:0] delay_lfsr  = 16'd18843;  // Separate stream for the RAM model

	// What the RAM saw during the last CPU access
	logic      ram_seen;
	ram_addr_t seen_addr;
	cpu_data_t seen_wdata;
	logic      seen_we;

	zx_mem_io zx_mem_io_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ============================================================
	// Reference helpers
	// ============================================================

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic draw_bits(inout logic [15:0] state, input int n, output logic [15:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			value = {value[14:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	// Memory contents follow a pattern over every address bit
	function automatic cpu_data_t ram_byte(input ram_addr_t a);
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'h5A;
	endfunction

	function automatic bank_t normal_bank(input cpu_addr_t a, input bank_t top,
		input logic [1:0] rom);
		case (a[15:14])
			2'd0:    return ROM_BANK_BASE + {4'd0, rom};
			2'd1:    return BANK_AT_4000;
			2'd2:    return BANK_AT_8000;
			default: return top;
		endcase
	endfunction

	function automatic bank_t special_bank(input logic [1:0] cfg, input logic [1:0] slot);
		logic [15:0] map;  // One nibble per slot with slot 0 on top
		case (cfg)
			2'd0:    map = 16'h0123;
			2'd1:    map = 16'h4567;
			2'd2:    map = 16'h4563;
			default: map = 16'h4763;
		endcase
		return bank_t'((map >> (4 * (3 - slot))) & 16'h000F);
	endfunction

	function automatic logic [4:0] joy_keys(input joy_mode_e mode, input cpu_addr_t addr,
		input logic [4:0] s);
		logic [4:0] keys;
		keys = 5'b00000;
		if (mode == joy_sinclair1 && !addr[12])
			keys = {s[1], s[0], s[2], s[3], s[4]};  // Left, right, down, up, fire
		if (mode == joy_sinclair2 && !addr[11])
			keys = {s[4], s[3], s[2], s[0], s[1]};  // Fire, up, down, right, left
		return keys;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ============================================================
	// Monitors and RAM model
	// ============================================================

	logic      hold_pending = 1'b0;
	ram_addr_t held_addr;
	cpu_data_t held_wdata;
	logic      held_we;

	// Request fields frozen while ram_ready is low
	always @(posedge clk_sys) begin
		if (!reset && hold_pending) begin
			check_value("ram_valid", ram_valid, 1'b1);
			check_value("ram_addr", ram_addr, held_addr);
			check_value("ram_wdata", ram_wdata, held_wdata);
			check_value("ram_we", ram_we, held_we);
		end
		hold_pending <= !reset && ram_valid && !ram_ready;
		held_addr    <= ram_addr;
		held_wdata   <= ram_wdata;
		held_we      <= ram_we;
	end

	a_wait_during_ram: assert property (@(posedge clk_sys) disable iff (reset)
		ram_valid |-> cpu_wait)
	else begin
		error_count++;
		$display("error at %0t: cpu_wait is 0 while ram_valid is high, expected 1", $time);
	end

	initial begin : ram_model
		int          delay;
		logic [15:0] bits;
		ram_ready = 1'b0;
		ram_rdata = 8'h00;
		delay     = -1;
		forever begin
			@(posedge clk_sys);
			#1;
			if (reset || !ram_valid) begin
				ram_ready = 1'b0;
				delay     = -1;
			end else begin
				if (delay < 0) begin
					draw_bits(delay_lfsr, 2, bits);  // 0 to 3 cycles
					delay = bits[1:0];
				end
				if (delay == 0) begin
					ram_ready = 1'b1;
					ram_rdata = ram_byte(ram_addr);
				end else begin
					ram_ready = 1'b0;
					delay     = delay - 1;
				end
			end
		end
	end

	initial begin
		#(CLK_PERIOD * RUN_CYCLES);
		$display("Watchdog expired after %0d cycles, the run did not complete", RUN_CYCLES);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("TEST FAILED");
		$finish;
	end

	// ============================================================
	// Bus cycles
	// ============================================================

	task automatic apply_reset(input machine_e m);
		@(posedge clk_sys);
		#1;
		reset   = 1'b1;
		machine = m;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	endtask

	task automatic mem_access(input cpu_addr_t addr, input logic we, input cpu_data_t wdata,
		output cpu_data_t rdata);
		int cycles;
		@(posedge clk_sys);
		#1;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_mreq  = 1'b1;
		cpu_rd    = !we;
		cpu_wr    = we;
		ram_seen  = 1'b0;
		@(posedge clk_sys);
		#1;
		check_value("cpu_wait", cpu_wait, 1'b1);  // Raised after the start edge
		cycles = 1;
		while (cpu_wait && cycles < ACCESS_LIMIT) begin
			if (ram_valid) begin
				ram_seen   = 1'b1;
				seen_addr  = ram_addr;
				seen_wdata = ram_wdata;
				seen_we    = ram_we;
			end
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		if (cpu_wait) begin
			error_count++;
			$display("CPU access to %h hung, cpu_wait still high after %0d cycles",
				addr, ACCESS_LIMIT);
		end
		rdata    = cpu_rdata;
		cpu_mreq = 1'b0;
		cpu_rd   = 1'b0;
		cpu_wr   = 1'b0;
	endtask

	task automatic io_write(input cpu_addr_t addr, input cpu_data_t data);
		@(posedge clk_sys);
		#1;
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_iorq  = 1'b1;
		cpu_wr    = 1'b1;
		@(posedge clk_sys);
		#1;
		cpu_iorq = 1'b0;
		cpu_wr   = 1'b0;
	endtask

	task automatic io_read(input cpu_addr_t addr, output cpu_data_t data);
		@(posedge clk_sys);
		#1;
		cpu_addr = addr;
		cpu_iorq = 1'b1;
		cpu_rd   = 1'b1;
		@(posedge clk_sys);
		#1;
		data     = cpu_rdata;
		cpu_iorq = 1'b0;
		cpu_rd   = 1'b0;
	endtask

	task automatic read_expect(input cpu_addr_t addr, input bank_t bank);
		ram_addr_t exp_addr;
		cpu_data_t rdata;
		exp_addr = {bank, addr[13:0]};
		mem_access(addr, 1'b0, 8'h00, rdata);
		check_value("ram_valid", ram_seen, 1'b1);
		check_value("ram_addr", seen_addr, exp_addr);
		check_value("ram_we", seen_we, 1'b0);
		check_value("cpu_rdata", rdata, ram_byte(exp_addr));
	endtask

	task automatic write_expect(input cpu_addr_t addr, input cpu_data_t data,
		input bank_t bank, input logic forwarded);
		cpu_data_t rdata;
		mem_access(addr, 1'b1, data, rdata);
		check_value("ram_valid", ram_seen, forwarded);
		if (forwarded) begin
			check_value("ram_addr", seen_addr, {bank, addr[13:0]});
			check_value("ram_wdata", seen_wdata, data);
			check_value("ram_we", seen_we, 1'b1);
		end
	endtask

	// ============================================================
	// Test sequences
	// ============================================================

	task automatic reset_state_checks();
		check_value("ram_valid", ram_valid, 1'b0);
		check_value("cpu_wait", cpu_wait, 1'b0);
		check_value("ear_out", ear_out, 1'b0);
		check_value("mic_out", mic_out, 1'b0);
		check_value("border", border, 3'd0);
		check_value("screen_bank", screen_bank, SCREEN_BANK_NORMAL);
		read_expect(16'hC000, 6'd0);
		read_expect(16'h0000, ROM_BANK_BASE);
	endtask

	task automatic paging_128k();
		io_write(16'h7FFD, 8'h1B);  // RAM 3, shadow screen, ROM 1
		read_expect(16'hD234, 6'd3);
		read_expect(16'h0100, ROM_BANK_BASE + 6'd1);
		read_expect(16'h4000, BANK_AT_4000);
		read_expect(16'hBFFF, BANK_AT_8000);
		check_value("screen_bank", screen_bank, SCREEN_BANK_SHADOW);
		io_write(16'h7FFD, 8'h06);
		read_expect(16'hFFFF, 6'd6);
		read_expect(16'h3FFF, ROM_BANK_BASE);
		check_value("screen_bank", screen_bank, SCREEN_BANK_NORMAL);
	endtask

	task automatic lock_and_48k();
		io_write(16'h7FFD, 8'h24);  // RAM 4 and lock
		read_expect(16'hC010, 6'd4);
		io_write(16'h7FFD, 8'h1F);
		read_expect(16'hC010, 6'd4);
		read_expect(16'h0010, ROM_BANK_BASE);
		check_value("screen_bank", screen_bank, SCREEN_BANK_NORMAL);
		apply_reset(zx48);
		io_write(16'h7FFD, 8'h0F);  // No paging on the 48K
		read_expect(16'hC020, 6'd0);
		read_expect(16'h0020, ROM_BANK_BASE + 6'd1);
		check_value("screen_bank", screen_bank, SCREEN_BANK_NORMAL);
	endtask

	task automatic plus3_special_modes();
		int c;
		int s;
		apply_reset(zx_plus3);
		for (c = 0; c < 4; c++) begin
			io_write(16'h1FFD, {5'b00000, c[1:0], 1'b1});
			for (s = 0; s < 4; s++)
				read_expect({s[1:0], 14'h0155}, special_bank(c[1:0], s[1:0]));
		end
		io_write(16'h1FFD, 8'h07);
		write_expect(16'h0123, 8'hA5, 6'd4, 1'b1);
		// Back to normal mode with ROM 3 so writes to 0000 are dropped
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		read_expect(16'h0123, ROM_BANK_BASE + 6'd3);
		write_expect(16'h0123, 8'h5A, ROM_BANK_BASE + 6'd3, 1'b0);
		read_expect(16'hC000, 6'd0);
	endtask

	task automatic ula_ports();
		int          i;
		logic [15:0] bits;
		cpu_addr_t   port;
		cpu_data_t   rdata;
		logic [4:0]  keys;
		io_write(16'h00FE, 8'h1D);
		check_value("border", border, 3'd5);
		check_value("mic_out", mic_out, 1'b1);
		check_value("ear_out", ear_out, 1'b1);
		io_write(16'hFEFE, 8'h02);
		check_value("border", border, 3'd2);
		check_value("mic_out", mic_out, 1'b0);
		check_value("ear_out", ear_out, 1'b0);
		// Interrupt acknowledge cycles are not port accesses
		cpu_m1 = 1'b1;
		io_write(16'h00FE, 8'h07);
		check_value("border", border, 3'd2);
		io_read(16'h00FE, rdata);
		check_value("cpu_rdata", rdata, IO_READ_IDLE);
		cpu_m1 = 1'b0;
		// Every mode against every A12/A11 combination
		for (i = 0; i < ULA_READS; i++) begin
			draw_bits(stim_lfsr, 11, bits);
			joy_state = bits[4:0];
			kbd_cols  = bits[9:5];
			ear_in    = bits[10];
			joy_mode  = joy_mode_e'(i % 3);
			case ((i / 3) % 4)
				0:       port = 16'hFEFE;
				1:       port = 16'hEFFE;
				2:       port = 16'hF7FE;
				default: port = 16'hE7FE;
			endcase
			io_read(port, rdata);
			keys = joy_keys(joy_mode, port, joy_state);
			check_value("cpu_rdata", rdata, {1'b1, ear_in, 1'b1, kbd_cols & ~keys});
		end
		joy_mode  = joy_kempston;
		joy_state = 5'h15;
		io_read(16'h001F, rdata);
		check_value("cpu_rdata", rdata, 8'h15);
		joy_mode = joy_sinclair2;
		io_read(16'h001F, rdata);
		check_value("cpu_rdata", rdata, 8'h00);
		io_read(16'h7FFD, rdata);  // Nobody answers
		check_value("cpu_rdata", rdata, IO_READ_IDLE);
	endtask

	task automatic random_handshake();
		int          i;
		logic [15:0] bits;
		cpu_addr_t   addr;
		bank_t       bank;
		apply_reset(zx128);
		io_write(16'h7FFD, 8'h01);
		for (i = 0; i < RANDOM_ACCESSES; i++) begin
			draw_bits(stim_lfsr, 16, bits);
			addr = bits;
			draw_bits(stim_lfsr, 9, bits);
			bank = normal_bank(addr, 6'd1, 2'd0);
			if (bits[8])
				write_expect(addr, bits[7:0], bank, addr[15:14] != 2'd0);
			else
				read_expect(addr, bank);
		end
	endtask

	initial begin
		reset     = 1'b1;
		machine   = zx128;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_mreq  = 1'b0;
		cpu_iorq  = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_m1    = 1'b0;
		kbd_cols  = 5'h1F;  // No key pressed
		ear_in    = 1'b0;
		joy_mode  = joy_kempston;
		joy_state = 5'h00;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		reset_state_checks();
		paging_128k();
		lock_and_48k();
		plus3_special_modes();
		ula_ports();
		random_handshake();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: zx_mem_io.f
hw/zx_bus_pkg.sv
hw/zx_arch_pkg.sv
hw/zx_io_if.sv
hw/zx_mem_if.sv
hw/zx_page_if.sv
hw/zx_cpu_bus.sv
hw/zx_paging.sv
hw/zx_mem_map.sv
hw/zx_ula_io.sv
hw/zx_mem_io.sv
verification/zx_mem_io_tb.sv
